//--- hdl/rv_pkg.sv
//--------------------------------------------------------------------------
// RV32 subsystem shared types
//--------------------------------------------------------------------------
package rv_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  sel_t;
    typedef logic [4:0]  reg_idx_t;

    //----------------------------------------------------------------------
    // wishbone classic
    //----------------------------------------------------------------------
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        sel_t  sel;
        word_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    // memory geometry, word addressed by adr[11:2]
    localparam int mem_words = 1024;
    typedef logic [9:0] mem_idx_t;

    //----------------------------------------------------------------------
    // base opcodes
    //----------------------------------------------------------------------
    typedef logic [6:0] op_t;

    localparam op_t OP_IMM = 7'b0010011;
    localparam op_t OP     = 7'b0110011;
    localparam op_t LOAD   = 7'b0000011;
    localparam op_t STORE  = 7'b0100011;
    localparam op_t BRANCH = 7'b1100011;
    localparam op_t SYSTEM = 7'b1110011;

    // instruction sequencer
    typedef enum logic [2:0] {
        idle,
        fetch,
        execute,
        memory,
        halt
    } exec_state_t;

endpackage

//--- hdl/rv_fetch.sv
//--------------------------------------------------------------------------
// Program counter and instruction fetch master
//--------------------------------------------------------------------------
module rv_fetch (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_go,
    input  logic            pc_load,
    input  rv_pkg::addr_t   next_pc,
    output rv_pkg::wb_m2s_t bus,
    input  rv_pkg::wb_s2m_t bus_rsp,
    output logic            fetch_valid,
    output rv_pkg::instr_t  instr,
    output rv_pkg::addr_t   pc
);

    // read in flight, set after the first request cycle
    logic busy_q;

    // request starts in the fetch_go cycle, pc is already stable then
    always_comb begin
        bus.cyc = fetch_go | busy_q;
        bus.stb = fetch_go | busy_q;
        bus.we  = 1'b0;
        bus.adr = pc;
        bus.sel = '1;
        bus.dat = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            fetch_valid <= 1'b0;
            pc          <= '0;
        end else begin
            if (busy_q) begin
                busy_q <= !bus_rsp.ack;
            end else begin
                busy_q <= fetch_go;
            end
            fetch_valid <= busy_q & bus_rsp.ack;
            if (pc_load) begin
                pc <= next_pc;
            end
        end
    end

    // instruction word held until the next fetch completes
    always_ff @(posedge clk) begin
        if (busy_q && bus_rsp.ack) begin
            instr <= bus_rsp.dat;
        end
    end

endmodule

//--- hdl/rv_exec.sv
//--------------------------------------------------------------------------
// Decode, register file and instruction sequencer
//--------------------------------------------------------------------------
module rv_exec (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           run,
    output logic           fetch_go,
    input  logic           fetch_valid,
    input  rv_pkg::instr_t instr,
    input  rv_pkg::addr_t  pc,
    output logic           pc_load,
    output rv_pkg::addr_t  next_pc,
    output logic           lsu_go,
    output rv_pkg::addr_t  lsu_addr,
    output rv_pkg::word_t  lsu_wdata,
    output logic           lsu_store,
    input  logic           lsu_done,
    input  rv_pkg::word_t  lsu_rdata,
    output logic           halted
);
    import rv_pkg::*;

    exec_state_t state_q;
    exec_state_t state_d;
    exec_state_t resume_state;

    op_t         opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  funct3;
    logic        is_ebreak;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       alu_result;
    logic        branch_taken;
    logic        rd_we;
    word_t       rd_wdata;
    word_t       regs [32];

    //----------------------------------------------------------------------
    // decode
    //----------------------------------------------------------------------
    assign opcode    = instr[6:0];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign is_ebreak = (instr[31:20] == 12'h001);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // x0 reads as zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // add/sub, funct7 bit 30 selects sub for OP
    always_comb begin
        if (opcode == OP && instr[30]) begin
            alu_result = rs1_val - rs2_val;
        end else if (opcode == OP) begin
            alu_result = rs1_val + rs2_val;
        end else begin
            alu_result = rs1_val + imm_i;
        end
    end

    // only BNE is decoded among the branches
    assign branch_taken = (funct3 == 3'b001) && (rs1_val != rs2_val);

    assign lsu_addr  = rs1_val + ((opcode == STORE) ? imm_s : imm_i);
    assign lsu_wdata = rs2_val;
    assign lsu_store = (opcode == STORE);

    //----------------------------------------------------------------------
    // sequencer
    //----------------------------------------------------------------------
    // park in idle while run is low so the host owns memory
    assign resume_state = run ? fetch : idle;

    always_comb begin
        state_d  = state_q;
        pc_load  = 1'b0;
        lsu_go   = 1'b0;
        rd_we    = 1'b0;
        rd_wdata = alu_result;
        next_pc  = pc + 32'd4;
        unique case (state_q)
            idle: begin
                if (run) begin
                    state_d = fetch;
                end
            end
            fetch: begin
                if (fetch_valid) begin
                    state_d = execute;
                end
            end
            execute: begin
                pc_load = 1'b1;
                state_d = resume_state;
                if (opcode == OP_IMM || opcode == OP) begin
                    rd_we = 1'b1;
                end else if (opcode == LOAD || opcode == STORE) begin
                    pc_load = 1'b0;
                    lsu_go  = 1'b1;
                    state_d = memory;
                end else if (opcode == BRANCH && branch_taken) begin
                    next_pc = pc + imm_b;
                end else if (opcode == SYSTEM && is_ebreak) begin
                    pc_load = 1'b0;
                    state_d = halt;
                end
            end
            memory: begin
                if (lsu_done) begin
                    rd_we    = (opcode == LOAD);
                    rd_wdata = lsu_rdata;
                    pc_load  = 1'b1;
                    state_d  = resume_state;
                end
            end
            halt: begin
                state_d = halt;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= idle;
            fetch_go <= 1'b0;
        end else begin
            state_q  <= state_d;
            // single pulse on entry to fetch
            fetch_go <= (state_d == fetch) && (state_q != fetch);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_we && rd != '0) begin
            regs[rd] <= rd_wdata;
        end
    end

    assign halted = (state_q == halt);

endmodule

//--- hdl/rv_lsu.sv
//--------------------------------------------------------------------------
// Load/store bus master
//--------------------------------------------------------------------------
module rv_lsu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            lsu_go,
    input  rv_pkg::addr_t   lsu_addr,
    input  rv_pkg::word_t   lsu_wdata,
    input  logic            lsu_store,
    output rv_pkg::wb_m2s_t bus,
    input  rv_pkg::wb_s2m_t bus_rsp,
    output logic            lsu_done,
    output rv_pkg::word_t   lsu_rdata
);
    import rv_pkg::*;

    logic  busy_q;
    addr_t addr_q;
    word_t wdata_q;
    logic  store_q;

    // first cycle comes straight from exec, later cycles from the latches
    always_comb begin
        bus.cyc = lsu_go | busy_q;
        bus.stb = lsu_go | busy_q;
        bus.we  = busy_q ? store_q : lsu_store;
        bus.adr = busy_q ? addr_q : lsu_addr;
        bus.sel = '1;
        bus.dat = busy_q ? wdata_q : lsu_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            if (busy_q) begin
                busy_q <= !bus_rsp.ack;
            end else begin
                busy_q <= lsu_go;
            end
            lsu_done <= busy_q & bus_rsp.ack;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_go && !busy_q) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
            store_q <= lsu_store;
        end
        if (busy_q && bus_rsp.ack) begin
            lsu_rdata <= bus_rsp.dat;
        end
    end

endmodule

//--- hdl/rv_mem_arbiter.sv
//--------------------------------------------------------------------------
// Three-master priority arbiter
//--------------------------------------------------------------------------
module rv_mem_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::wb_m2s_t data_bus,
    input  rv_pkg::wb_m2s_t fetch_bus,
    input  rv_pkg::wb_m2s_t host_bus,
    output rv_pkg::wb_s2m_t data_rsp,
    output rv_pkg::wb_s2m_t fetch_rsp,
    output rv_pkg::wb_s2m_t host_rsp,
    output rv_pkg::wb_m2s_t mem_bus,
    input  rv_pkg::wb_s2m_t mem_rsp
);

    // one-hot, bit 0 data, bit 1 fetch, bit 2 host
    logic [2:0] req;
    logic [2:0] owner_q;
    logic [2:0] grant;
    logic       owner_active;

    assign req          = {host_bus.cyc, fetch_bus.cyc, data_bus.cyc};
    assign owner_active = |(owner_q & req);

    // current owner keeps the bus until its cyc drops
    always_comb begin
        if (owner_active) begin
            grant = owner_q;
        end else if (req[0]) begin
            grant = 3'b001;
        end else if (req[1]) begin
            grant = 3'b010;
        end else if (req[2]) begin
            grant = 3'b100;
        end else begin
            grant = 3'b000;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= '0;
        end else begin
            owner_q <= grant;
        end
    end

    always_comb begin
        unique case (grant)
            3'b001:  mem_bus = data_bus;
            3'b010:  mem_bus = fetch_bus;
            3'b100:  mem_bus = host_bus;
            default: mem_bus = '0;
        endcase
    end

    // read data fans out, ack only to the owner
    always_comb begin
        data_rsp      = mem_rsp;
        fetch_rsp     = mem_rsp;
        host_rsp      = mem_rsp;
        data_rsp.ack  = mem_rsp.ack & grant[0];
        fetch_rsp.ack = mem_rsp.ack & grant[1];
        host_rsp.ack  = mem_rsp.ack & grant[2];
    end

endmodule

//--- hdl/rv_sram.sv
//--------------------------------------------------------------------------
// Single-port word SRAM with byte select
//--------------------------------------------------------------------------
module rv_sram (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::wb_m2s_t bus,
    output rv_pkg::wb_s2m_t bus_rsp
);
    import rv_pkg::*;

    word_t    mem [mem_words];
    mem_idx_t idx;
    logic     access;
    logic     ack_q;
    word_t    rdata_q;

    assign idx = bus.adr[11:2];

    // no new access in the ack cycle, so ack never repeats back to back
    assign access = bus.cyc & bus.stb & !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus_rsp.ack = ack_q;
    assign bus_rsp.dat = rdata_q;

endmodule

//--- hdl/rv_subsys_top.sv
//--------------------------------------------------------------------------
// RV32 core subsystem top
//--------------------------------------------------------------------------
module rv_subsys_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  rv_pkg::wb_m2s_t host_bus,
    output rv_pkg::wb_s2m_t host_rsp,
    output logic            halted
);
    import rv_pkg::*;

    // bus side
    wb_m2s_t fetch_bus;
    wb_m2s_t data_bus;
    wb_m2s_t mem_bus;
    wb_s2m_t fetch_rsp;
    wb_s2m_t data_rsp;
    wb_s2m_t mem_rsp;

    // core control
    logic    fetch_go;
    logic    fetch_valid;
    logic    pc_load;
    instr_t  instr;
    addr_t   pc;
    addr_t   next_pc;
    logic    lsu_go;
    logic    lsu_store;
    logic    lsu_done;
    addr_t   lsu_addr;
    word_t   lsu_wdata;
    word_t   lsu_rdata;

    rv_fetch u_fetch (
        .*,
        .bus     (fetch_bus),
        .bus_rsp (fetch_rsp)
    );

    rv_exec u_exec (.*);

    rv_lsu u_lsu (
        .*,
        .bus     (data_bus),
        .bus_rsp (data_rsp)
    );

    rv_mem_arbiter u_arbiter (.*);

    rv_sram u_sram (
        .*,
        .bus     (mem_bus),
        .bus_rsp (mem_rsp)
    );

endmodule

//--- sim/rv_subsys_asserts.sv
//--------------------------------------------------------------------------
// Arbiter bus protocol assertions
//--------------------------------------------------------------------------
module rv_subsys_asserts (
    input logic            clk,
    input logic            rst_n,
    input rv_pkg::wb_m2s_t data_bus,
    input rv_pkg::wb_m2s_t fetch_bus,
    input rv_pkg::wb_m2s_t host_bus,
    input rv_pkg::wb_m2s_t mem_bus,
    input rv_pkg::wb_s2m_t mem_rsp,
    input rv_pkg::wb_s2m_t data_rsp,
    input rv_pkg::wb_s2m_t fetch_rsp,
    input rv_pkg::wb_s2m_t host_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertion count
    int unsigned fail_count = 0;

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |-> mem_bus.stb)
        else begin
            $error("sram ack without a strobe");
            fail_count++;
        end

    // every sram ack lands on exactly one master that is still strobing
    single_owner_ack: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |-> $onehot({data_rsp.ack & data_bus.stb,
                                 fetch_rsp.ack & fetch_bus.stb,
                                 host_rsp.ack & host_bus.stb}))
        else begin
            $error("sram ack not returned to exactly one strobing master");
            fail_count++;
        end

    // request frozen until the slave answers
    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_bus.stb && !mem_rsp.ack |=> $stable(mem_bus))
        else begin
            $error("memory request changed while waiting for ack");
            fail_count++;
        end

    // the acked request is gone in the next cycle
    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |=> !mem_rsp.ack && !(mem_bus.stb && $stable(mem_bus)))
        else begin
            $error("sram ack repeated or request held after ack");
            fail_count++;
        end

endmodule

bind rv_mem_arbiter rv_subsys_asserts u_asserts (.*);

//--- sim/tb_rv_subsys.sv
//--------------------------------------------------------------------------
// RV32 subsystem testbench
//--------------------------------------------------------------------------
module tb_rv_subsys;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int host_tests   = 16;
    // worst case instruction counts of doubler, fibonacci and load loop
    localparam int max_instr    = 35 + 103 + 47;
    localparam int host_ops     = 400;
    localparam int watchdog_cycles =
        20 * max_instr + 6 * host_ops + 4 * (reset_cycles + 1) + 500;

    localparam addr_t result_addr = 32'd3840;
    localparam addr_t table_addr  = 32'd3600;
    localparam addr_t sum_addr    = 32'd3880;
    localparam instr_t ebreak_code = 32'h0010_0073;

    localparam reg_idx_t x0  = 5'd0;
    localparam reg_idx_t x1  = 5'd1;
    localparam reg_idx_t x2  = 5'd2;
    localparam reg_idx_t x3  = 5'd3;
    localparam reg_idx_t x5  = 5'd5;
    localparam reg_idx_t x6  = 5'd6;
    localparam reg_idx_t x7  = 5'd7;
    localparam reg_idx_t x8  = 5'd8;
    localparam reg_idx_t x9  = 5'd9;
    localparam reg_idx_t x10 = 5'd10;

    typedef struct packed {
        addr_t addr;
        word_t got;
        word_t exp;
    } read_check_t;

    typedef struct packed {
        word_t x1;
        word_t x2;
        word_t x3;
    } fib_t;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        halted;
    wb_m2s_t     host_bus;
    wb_s2m_t     host_rsp;
    logic [31:0] lfsr_state = 32'h6c13_68c9;
    read_check_t check_q[$];
    instr_t      prog[$];

    rv_subsys_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //----------------------------------------------------------------------
    // random bits and instruction encoders
    //----------------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t addi_code(input reg_idx_t rd, input reg_idx_t rs1,
                                         input word_t imm);
        return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic instr_t add_code(input reg_idx_t rd, input reg_idx_t rs1,
                                        input reg_idx_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, OP};
    endfunction

    function automatic instr_t sub_code(input reg_idx_t rd, input reg_idx_t rs1,
                                        input reg_idx_t rs2);
        return {7'b0100000, rs2, rs1, 3'b000, rd, OP};
    endfunction

    function automatic instr_t lw_code(input reg_idx_t rd, input reg_idx_t rs1,
                                       input word_t imm);
        return {imm[11:0], rs1, 3'b010, rd, LOAD};
    endfunction

    function automatic instr_t sw_code(input reg_idx_t rs2, input reg_idx_t rs1,
                                       input word_t imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic instr_t bne_code(input reg_idx_t rs1, input reg_idx_t rs2,
                                        input word_t off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], BRANCH};
    endfunction

    //----------------------------------------------------------------------
    // reference models
    //----------------------------------------------------------------------
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input sel_t sel);
        word_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic word_t doubler_ref(input int n);
        return 32'd1 << n;
    endfunction

    function automatic fib_t fib_ref(input int n);
        fib_t f;
        f.x1 = 32'd0;
        f.x2 = 32'd1;
        f.x3 = 32'd0;
        repeat (n) begin
            f.x3 = f.x1 + f.x2;
            f.x1 = f.x2;
            f.x2 = f.x3;
        end
        return f;
    endfunction

    function automatic word_t sum_ref(input word_t vals [8]);
        word_t s = '0;
        foreach (vals[i]) s = s + vals[i];
        return s;
    endfunction

    //----------------------------------------------------------------------
    // checks
    //----------------------------------------------------------------------
    task automatic abort(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    initial begin : compare
        read_check_t c;
        forever begin
            wait (check_q.size() != 0);
            c = check_q.pop_front();
            check_word($sformatf("word at %h", c.addr), c.got, c.exp);
        end
    end

    initial begin : assert_watch
        wait (dut.u_arbiter.u_asserts.fail_count != 0);
        abort("a bus protocol assertion failed");
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        abort("watchdog expired before the tests finished");
    end

    //----------------------------------------------------------------------
    // host port and core control
    //----------------------------------------------------------------------
    task automatic bus_access(input logic we, input addr_t adr, input sel_t sel,
                              input word_t wdata, output word_t rdata);
        wb_m2s_t req;
        int      waited;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.sel = sel;
        req.dat = wdata;
        @(posedge clk);
        host_bus <= req;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 16) begin
                abort("host bus cycle was never acknowledged");
            end
        end while (!host_rsp.ack);
        rdata = host_rsp.dat;
        @(posedge clk);
        host_bus <= '0;
    endtask

    task automatic host_write(input addr_t adr, input word_t data, input sel_t sel);
        word_t unused;
        bus_access(1'b1, adr, sel, data, unused);
    endtask

    task automatic host_read(input addr_t adr, output word_t data);
        bus_access(1'b0, adr, 4'hf, '0, data);
    endtask

    // read back and hand to the compare process
    task automatic read_expect(input addr_t adr, input word_t exp);
        word_t got;
        host_read(adr, got);
        check_q.push_back(read_check_t'{addr: adr, got: got, exp: exp});
    endtask

    task automatic reset_dut();
        @(posedge clk);
        run   <= 1'b0;
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("halted after reset", halted, 1'b0);
    endtask

    task automatic load_program();
        foreach (prog[i]) host_write(addr_t'(4 * i), prog[i], 4'hf);
    endtask

    // start at pc 0, wait for EBREAK, then confirm the core stays quiet
    task automatic run_and_hold(input int n_instr);
        int waited;
        int hold;
        @(posedge clk);
        run <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20 * n_instr + 50) begin
                abort("program did not reach EBREAK in time");
            end
        end while (!halted);
        hold = 8 + int'(rand_bits(4));
        repeat (hold) begin
            @(negedge clk);
            check_flag("halted while held", halted, 1'b1);
        end
        foreach (prog[i]) read_expect(addr_t'(4 * i), prog[i]);
        check_flag("halted after host reads", halted, 1'b1);
    endtask

    //----------------------------------------------------------------------
    // tests
    //----------------------------------------------------------------------
    task automatic host_access_test();
        word_t r;
        addr_t a;
        word_t first;
        word_t second;
        sel_t  sel;
        repeat (host_tests) begin
            r      = rand_bits(10);
            a      = r << 2;
            first  = rand_bits(32);
            second = rand_bits(32);
            r      = rand_bits(4);
            sel    = r[3:0];
            host_write(a, first, 4'hf);
            host_write(a, second, sel);
            read_expect(a, merge_bytes(first, second, sel));
        end
    endtask

    task automatic doubler_test();
        word_t r;
        int    n;
        r = rand_bits(5);
        n = 1 + int'(r % 32'd31);
        prog.delete();
        prog.push_back(addi_code(x1, x0, 1));
        repeat (n) prog.push_back(add_code(x1, x1, x1));
        prog.push_back(addi_code(x5, x0, 1920));
        prog.push_back(sw_code(x1, x5, 1920));
        prog.push_back(ebreak_code);
        load_program();
        run_and_hold(prog.size());
        read_expect(result_addr, doubler_ref(n));
        reset_dut();
    endtask

    task automatic fibonacci_test();
        word_t r;
        int    n;
        fib_t  f;
        r = rand_bits(5);
        n = 1 + int'(r);
        prog.delete();
        prog.push_back(addi_code(x1, x0, 0));
        prog.push_back(addi_code(x2, x0, 1));
        repeat (n) begin
            prog.push_back(add_code(x3, x1, x2));
            prog.push_back(addi_code(x1, x2, 0));
            prog.push_back(addi_code(x2, x3, 0));
        end
        prog.push_back(addi_code(x5, x0, 1920));
        prog.push_back(sw_code(x1, x5, 1920));
        prog.push_back(sw_code(x2, x5, 1924));
        prog.push_back(sw_code(x3, x5, 1928));
        prog.push_back(ebreak_code);
        load_program();
        run_and_hold(prog.size() + 1);
        f = fib_ref(n);
        read_expect(result_addr, f.x1);
        read_expect(result_addr + 32'd4, f.x2);
        read_expect(result_addr + 32'd8, f.x3);
        reset_dut();
    endtask

    task automatic load_loop_test();
        word_t vals [8];
        foreach (vals[i]) begin
            vals[i] = rand_bits(32);
            host_write(table_addr + addr_t'(4 * i), vals[i], 4'hf);
        end
        prog.delete();
        prog.push_back(addi_code(x5, x0, 1920));
        prog.push_back(addi_code(x6, x5, 1680));
        prog.push_back(addi_code(x7, x0, 8));
        prog.push_back(addi_code(x8, x0, 1));
        prog.push_back(addi_code(x9, x0, 0));
        // loop body at word 5
        prog.push_back(lw_code(x10, x6, 0));
        prog.push_back(add_code(x9, x9, x10));
        prog.push_back(addi_code(x6, x6, 4));
        prog.push_back(sub_code(x7, x7, x8));
        prog.push_back(bne_code(x7, x0, -16));
        prog.push_back(sw_code(x9, x5, 1960));
        prog.push_back(ebreak_code);
        load_program();
        run_and_hold(47);
        read_expect(sum_addr, sum_ref(vals));
        foreach (vals[i]) read_expect(table_addr + addr_t'(4 * i), vals[i]);
        reset_dut();
    endtask

    initial begin : main
        run      <= 1'b0;
        rst_n    <= 1'b0;
        host_bus <= '0;
        reset_dut();
        host_access_test();
        doubler_test();
        fibonacci_test();
        load_loop_test();
        wait (check_q.size() == 0);
        @(negedge clk);
        if (dut.u_arbiter.u_asserts.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort("a bus protocol assertion failed");
        end
    end

endmodule

//--- tb.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_exec.sv
hdl/rv_lsu.sv
hdl/rv_mem_arbiter.sv
hdl/rv_sram.sv
hdl/rv_subsys_top.sv
sim/rv_subsys_asserts.sv
sim/tb_rv_subsys.sv
